// ==== logic/procyon_pkg.sv ====
// shared sizes and types for the core; ROB_DEPTH must be a power of two and the multiplier assumes MUL_STAGES is 3
`default_nettype none

package procyon_pkg;

    localparam int DATA_WIDTH    = 32;
    localparam int RDST_WIDTH    = 5;
    localparam int ROB_DEPTH     = 8;
    localparam int ROB_IDX_WIDTH = $clog2(ROB_DEPTH);
    localparam int MUL_STAGES    = 3;

    // derived datapath sizes
    localparam int SHAMT_WIDTH   = $clog2(DATA_WIDTH);
    localparam int HALF_WIDTH    = DATA_WIDTH / 2;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SLT,
        MUL
    } op_e;

    typedef enum logic [1:0] {
        EMPTY,
        ISSUED,
        DONE
    } rob_state_e;

    // operands arrive already resolved
    typedef struct packed {
        logic                     valid;
        op_e                      op;
        logic [RDST_WIDTH-1:0]    rdst;
        logic [DATA_WIDTH-1:0]    src_a;
        logic [DATA_WIDTH-1:0]    src_b;
    } dispatch_t;

    typedef struct packed {
        logic                     valid;
        op_e                      op;
        logic [ROB_IDX_WIDTH-1:0] tag;
        logic [DATA_WIDTH-1:0]    src_a;
        logic [DATA_WIDTH-1:0]    src_b;
    } issue_t;

    typedef struct packed {
        logic                     valid;
        logic [ROB_IDX_WIDTH-1:0] tag;
        logic [DATA_WIDTH-1:0]    data;
    } cdb_t;

    typedef struct packed {
        logic                     valid;
        logic [RDST_WIDTH-1:0]    rdst;
        logic [DATA_WIDTH-1:0]    data;
    } retire_t;

endpackage

`default_nettype wire

// ==== logic/procyon_ieu.sv ====
// single-cycle integer unit; never stalls, MUL must not be issued here, result is valid one cycle after issue
`default_nettype none
`timescale 1ns/100ps

module procyon_ieu (
    input  wire                  clk,
    input  wire                  i_rst_n,
    input  wire procyon_pkg::issue_t i_issue,
    output procyon_pkg::cdb_t    o_cdb
);

    import procyon_pkg::*;

    logic [DATA_WIDTH-1:0]  result;
    logic [SHAMT_WIDTH-1:0] shamt;

    assign shamt = i_issue.src_b[SHAMT_WIDTH-1:0];

    always_comb begin
        case (i_issue.op)
            ADD:     result = i_issue.src_a + i_issue.src_b;
            SUB:     result = i_issue.src_a - i_issue.src_b;
            AND:     result = i_issue.src_a & i_issue.src_b;
            OR:      result = i_issue.src_a | i_issue.src_b;
            XOR:     result = i_issue.src_a ^ i_issue.src_b;
            SLL:     result = i_issue.src_a << shamt;
            SRL:     result = i_issue.src_a >> shamt;
            // signed compare
            SLT: begin
                result = {{(DATA_WIDTH-1){1'b0}},
                          $signed(i_issue.src_a) < $signed(i_issue.src_b)};
            end
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_cdb.valid <= 1'b0;
        end else begin
            o_cdb.valid <= i_issue.valid;
        end

        if (i_issue.valid) begin
            o_cdb.tag  <= i_issue.tag;
            o_cdb.data <= result;
        end
    end

    // the ROB routes every multiply to the other unit
    a_no_mul: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_issue.valid |-> (i_issue.op != MUL)
    ) else $error("multiply issued to integer unit");

endmodule

`default_nettype wire

// ==== logic/procyon_mul.sv ====
// pipelined multiplier returning the low DATA_WIDTH bits of the product; accepts one MUL per cycle, no stall
`default_nettype none
`timescale 1ns/100ps

module procyon_mul (
    input  wire                  clk,
    input  wire                  i_rst_n,
    input  wire procyon_pkg::issue_t i_issue,
    output procyon_pkg::cdb_t    o_cdb
);

    import procyon_pkg::*;

    // valid and tag travel beside the datapath
    logic [MUL_STAGES-2:0]    vld_q;
    logic [ROB_IDX_WIDTH-1:0] tag_q [MUL_STAGES-1];

    logic [DATA_WIDTH-1:0] pp_ll_q;
    logic [DATA_WIDTH-1:0] pp_lh_q;
    logic [DATA_WIDTH-1:0] pp_hl_q;
    logic [DATA_WIDTH-1:0] pp_ll_s2_q;
    logic [HALF_WIDTH-1:0] cross_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            vld_q       <= '0;
            o_cdb.valid <= 1'b0;
        end else begin
            vld_q[0] <= i_issue.valid;
            for (int i = 1; i < MUL_STAGES - 1; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
            o_cdb.valid <= vld_q[MUL_STAGES-2];
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= i_issue.tag;
        for (int i = 1; i < MUL_STAGES - 1; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
        o_cdb.tag <= tag_q[MUL_STAGES-2];
    end

    //////////////////////////////////////////////////////////////////////
    // stage 1 forms partial products, hi*hi only reaches the dropped bits
    always_ff @(posedge clk) begin
        if (i_issue.valid) begin
            pp_ll_q <= i_issue.src_a[HALF_WIDTH-1:0] * i_issue.src_b[HALF_WIDTH-1:0];
            pp_lh_q <= i_issue.src_a[HALF_WIDTH-1:0] * i_issue.src_b[DATA_WIDTH-1:HALF_WIDTH];
            pp_hl_q <= i_issue.src_a[DATA_WIDTH-1:HALF_WIDTH] * i_issue.src_b[HALF_WIDTH-1:0];
        end
    end

    // stage 2 folds the cross terms, only their low half survives the shift
    always_ff @(posedge clk) begin
        if (vld_q[0]) begin
            pp_ll_s2_q <= pp_ll_q;
            cross_q    <= pp_lh_q[HALF_WIDTH-1:0] + pp_hl_q[HALF_WIDTH-1:0];
        end
    end

    // final sum
    always_ff @(posedge clk) begin
        if (vld_q[MUL_STAGES-2]) begin
            o_cdb.data <= pp_ll_s2_q + {cross_q, {HALF_WIDTH{1'b0}}};
        end
    end

    a_only_mul: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_issue.valid |-> (i_issue.op == MUL)
    ) else $error("non-multiply issued to multiplier");

endmodule

`default_nettype wire

// ==== logic/procyon_rob.sv ====
// in-order reorder buffer; source must hold a dispatch while stalled, retire has no back-pressure
`default_nettype none
`timescale 1ns/100ps

module procyon_rob (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire procyon_pkg::dispatch_t i_dispatch,
    input  wire procyon_pkg::cdb_t  i_ieu_cdb,
    input  wire procyon_pkg::cdb_t  i_mul_cdb,
    output logic                    o_dispatch_stall,
    output procyon_pkg::issue_t     o_ieu_issue,
    output procyon_pkg::issue_t     o_mul_issue,
    output procyon_pkg::retire_t    o_retire
);

    import procyon_pkg::*;

    rob_state_e              state_q [ROB_DEPTH];
    logic [RDST_WIDTH-1:0]   rdst_q  [ROB_DEPTH];
    logic [DATA_WIDTH-1:0]   data_q  [ROB_DEPTH];

    logic [ROB_IDX_WIDTH-1:0] head_q;
    logic [ROB_IDX_WIDTH-1:0] tail_q;
    logic [ROB_IDX_WIDTH:0]   count_q;

    logic   accept;
    logic   is_mul;
    logic   retire_en;
    issue_t issue_d;

    assign o_dispatch_stall = (count_q == (ROB_IDX_WIDTH+1)'(ROB_DEPTH));
    assign accept           = i_dispatch.valid && !o_dispatch_stall;
    assign is_mul           = (i_dispatch.op == MUL);
    assign retire_en        = (state_q[head_q] == DONE);

    //////////////////////////////////////////////////////////////////////
    // dispatch and issue
    always_comb begin
        issue_d.valid = accept;
        issue_d.op    = i_dispatch.op;
        issue_d.tag   = tail_q;
        issue_d.src_a = i_dispatch.src_a;
        issue_d.src_b = i_dispatch.src_b;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_ieu_issue <= issue_d;
            o_mul_issue <= issue_d;
        end

        // only the valid bits matter after reset
        if (!i_rst_n) begin
            o_ieu_issue.valid <= 1'b0;
            o_mul_issue.valid <= 1'b0;
        end else begin
            o_ieu_issue.valid <= issue_d.valid && !is_mul;
            o_mul_issue.valid <= issue_d.valid && is_mul;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // entry state
    // writes in one cycle always hit different entries
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state_q[i] <= EMPTY;
            end
        end else begin
            if (accept) begin
                state_q[tail_q] <= ISSUED;
            end
            if (i_ieu_cdb.valid) begin
                state_q[i_ieu_cdb.tag] <= DONE;
            end
            if (i_mul_cdb.valid) begin
                state_q[i_mul_cdb.tag] <= DONE;
            end
            if (retire_en) begin
                state_q[head_q] <= EMPTY;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdst_q[tail_q] <= i_dispatch.rdst;
        end
        if (i_ieu_cdb.valid) begin
            data_q[i_ieu_cdb.tag] <= i_ieu_cdb.data;
        end
        if (i_mul_cdb.valid) begin
            data_q[i_mul_cdb.tag] <= i_mul_cdb.data;
        end
    end

    // pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (accept) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire_en) begin
                head_q <= head_q + 1'b1;
            end
            case ({accept, retire_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // retire
    always_ff @(posedge clk) begin
        if (retire_en) begin
            o_retire.rdst <= rdst_q[head_q];
            o_retire.data <= data_q[head_q];
        end

        if (!i_rst_n) begin
            o_retire.valid <= 1'b0;
        end else begin
            o_retire.valid <= retire_en;
        end
    end

    // completions come only for instructions still waiting on a unit
    a_ieu_cdb_issued: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_ieu_cdb.valid |-> (state_q[i_ieu_cdb.tag] == ISSUED)
    ) else $error("integer result for entry not in flight");

    a_mul_cdb_issued: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_mul_cdb.valid |-> (state_q[i_mul_cdb.tag] == ISSUED)
    ) else $error("multiply result for entry not in flight");

    a_cdb_tag_unique: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !(i_ieu_cdb.valid && i_mul_cdb.valid && (i_ieu_cdb.tag == i_mul_cdb.tag))
    ) else $error("both result ports carry the same tag");

    a_count_bound: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        count_q <= (ROB_IDX_WIDTH+1)'(ROB_DEPTH)
    ) else $error("entry count above depth");

endmodule

`default_nettype wire

// ==== logic/procyon_core.sv ====
// back end top with resolved operands at dispatch; no flush, no memory ops, one retire per cycle at most
`default_nettype none
`timescale 1ns/100ps

module procyon_core (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire procyon_pkg::dispatch_t i_dispatch,
    output logic                    o_dispatch_stall,
    output procyon_pkg::retire_t    o_retire
);

    import procyon_pkg::*;

    issue_t ieu_issue;
    issue_t mul_issue;
    cdb_t   ieu_cdb;
    cdb_t   mul_cdb;

    procyon_rob u_rob (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_dispatch       (i_dispatch),
        .i_ieu_cdb        (ieu_cdb),
        .i_mul_cdb        (mul_cdb),
        .o_dispatch_stall (o_dispatch_stall),
        .o_ieu_issue      (ieu_issue),
        .o_mul_issue      (mul_issue),
        .o_retire         (o_retire)
    );

    // the two units run side by side, each on its own result port
    procyon_ieu u_ieu (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_issue (ieu_issue),
        .o_cdb   (ieu_cdb)
    );

    procyon_mul u_mul (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_issue (mul_issue),
        .o_cdb   (mul_cdb)
    );

endmodule

`default_nettype wire

// ==== tb/procyon_model.svh ====
// reference model, include inside a module that imports procyon_pkg; retire order equals dispatch order
`ifndef PROCYON_MODEL_SVH
`define PROCYON_MODEL_SVH

// results still owed by the core, oldest first
retire_t expected_q[$];
int      in_flight;

function automatic logic [DATA_WIDTH-1:0] model_result(input op_e op,
                                                      input logic [DATA_WIDTH-1:0] a,
                                                      input logic [DATA_WIDTH-1:0] b);
    logic [2*DATA_WIDTH-1:0] product;
    int                      amount;
    amount  = b % DATA_WIDTH;
    product = {{DATA_WIDTH{1'b0}}, a} * {{DATA_WIDTH{1'b0}}, b};
    case (op)
        ADD:     return a + b;
        SUB:     return a + ~b + 1'b1;
        AND:     return a & b;
        OR:      return a | b;
        XOR:     return a ^ b;
        SLL:     return a << amount;
        SRL:     return a >> amount;
        SLT:     return ($signed(a) < $signed(b)) ? 1 : 0;
        MUL:     return product[DATA_WIDTH-1:0];
        default: return 'x;
    endcase
endfunction

function automatic void model_accept(input dispatch_t d);
    retire_t r;
    r.valid = 1'b1;
    r.rdst  = d.rdst;
    r.data  = model_result(d.op, d.src_a, d.src_b);
    expected_q.push_back(r);
    in_flight++;
endfunction

`endif

// ==== tb/procyon_tb.sv ====
// random dispatch testbench for the core; one retire per cycle expected, stall compared with the model count
`default_nettype none
`timescale 1ns/100ps

module procyon_tb;

    import procyon_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM     = 300;
    localparam int N_BURST      = 24;
    localparam int N_DISPATCH   = N_RANDOM + N_BURST;
    localparam int DRAIN_CYCLES = 10 * ROB_DEPTH;
    localparam int TIMEOUT_NS   = (N_DISPATCH * 20 + 2000) * CLK_PERIOD;

    logic      clk;
    logic      i_rst_n;
    dispatch_t i_dispatch;
    logic      o_dispatch_stall;
    retire_t   o_retire;

    integer seed;
    int     accepted_cnt;
    int     retired_cnt;
    int     drain_cnt;
    logic   last_accepted;

    `include "procyon_model.svh"

    procyon_core u_dut (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_dispatch       (i_dispatch),
        .o_dispatch_stall (o_dispatch_stall),
        .o_retire         (o_retire)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // checks
    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        fail_run();
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got !== exp) begin
            report_error($sformatf("retire rdst %0d data %h, expected rdst %0d data %h",
                                   got.rdst, got.data, exp.rdst, exp.data));
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("dispatch stall %b, expected %b with %0d in flight",
                                   got, exp, in_flight));
        end
    endtask

    // called at the falling edge, outputs are settled by then
    task automatic observe_outputs();
        retire_t exp;
        if (o_retire.valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                report_error("retire strobe with no instruction in flight");
            end else begin
                exp = expected_q.pop_front();
                check_retire(o_retire, exp);
                in_flight--;
                retired_cnt++;
            end
        end else if (o_retire.valid !== 1'b0) begin
            report_error("retire valid is unknown");
        end
        check_stall(o_dispatch_stall, in_flight == ROB_DEPTH);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    // a refused dispatch is held until taken
    task automatic drive_dispatch(input bit enable, input bit mul_only);
        dispatch_t d;
        int        pick;
        if (i_dispatch.valid && !last_accepted) begin
            d = i_dispatch;
        end else begin
            pick    = $unsigned($random(seed)) % 100;
            d.valid = enable && (mul_only || pick < 65);
            d.op    = mul_only ? MUL : op_e'($unsigned($random(seed)) % 9);
            d.rdst  = RDST_WIDTH'($random(seed));
            d.src_a = $random(seed);
            d.src_b = $random(seed);
        end
        i_dispatch    = d;
        // stall only moves on the rising edge, so this is what the next edge sees
        last_accepted = d.valid && !o_dispatch_stall;
        if (last_accepted) begin
            model_accept(d);
            accepted_cnt++;
        end
    endtask

    initial begin
        clk           = 1'b0;
        i_rst_n       = 1'b0;
        i_dispatch    = '0;
        seed          = 59618;
        accepted_cnt  = 0;
        retired_cnt   = 0;
        drain_cnt     = 0;
        last_accepted = 1'b0;
        in_flight     = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        // quiet after reset
        repeat (5) begin
            @(negedge clk);
            observe_outputs();
        end

        repeat (N_RANDOM) begin
            @(negedge clk);
            observe_outputs();
            drive_dispatch(1'b1, 1'b0);
        end

        // back to back multiplies with valid held high
        repeat (N_BURST) begin
            @(negedge clk);
            observe_outputs();
            drive_dispatch(1'b1, 1'b1);
        end

        // let the core drain
        while ((expected_q.size() != 0 || i_dispatch.valid) && drain_cnt < DRAIN_CYCLES) begin
            @(negedge clk);
            observe_outputs();
            drive_dispatch(1'b0, 1'b0);
            drain_cnt++;
        end

        // no stray retires once drained
        repeat (10) begin
            @(negedge clk);
            observe_outputs();
        end

        if (retired_cnt != accepted_cnt || expected_q.size() != 0) begin
            report_error($sformatf("retired %0d of %0d accepted instructions",
                                   retired_cnt, accepted_cnt));
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns before the drain finished", TIMEOUT_NS);
        fail_run();
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+tb
logic/procyon_pkg.sv
logic/procyon_ieu.sv
logic/procyon_mul.sv
logic/procyon_rob.sv
logic/procyon_core.sv
tb/procyon_tb.sv
